/* rtl/mandel_pkg.sv */
// Mandelbrot renderer shared definitions
// Fixed-point and counter widths, configuration word layout, FSM states

package mandel_pkg;

    // Default datapath widths
    localparam int BITWIDTH = 11;   // Signed, BITWIDTH-3 fraction bits
    localparam int CTRWIDTH = 7;

    // Serial configuration word
    localparam int CFG_BITS = 33;

    // Field positions inside the configuration word
    localparam int CR_LSB     = 0;    // Real offset, 11 bits
    localparam int CI_LSB     = 11;   // Imaginary offset, 11 bits
    localparam int SCALE_LSB  = 22;   // Pixel step exponent
    localparam int CSEL_LSB   = 24;   // Nibble select of the count
    localparam int MAXCTR_LSB = 26;   // Iteration limit, up to bit 32

    typedef logic signed [BITWIDTH-1:0] fix_t;
    typedef logic [CTRWIDTH-1:0]        ctr_t;
    typedef logic [1:0]                 scale_t;
    typedef logic [1:0]                 csel_t;
    typedef logic [3:0]                 nibble_t;

    // Render sequencer
    typedef enum logic [1:0] {
        idle,
        launch,
        wait_space,
        compute
    } seq_state_t;

    // Iteration engine
    typedef enum logic {
        eng_idle,
        eng_iter
    } eng_state_t;

endpackage

/* rtl/config_shift_in.sv */
// Serial configuration port
// Synchronizes sen/sclk/sdata, shifts in the 33-bit config word
// and flags a frame start on the falling edge of sen

module config_shift_in #(
    parameter int BITWIDTH = mandel_pkg::BITWIDTH,
    parameter int CTRWIDTH = mandel_pkg::CTRWIDTH
) (
    input  logic               clk,
    input  logic               combined_rst_n,
    input  logic               sen,
    input  logic               sclk,
    input  logic               sdata,
    output mandel_pkg::fix_t   cr_offset,
    output mandel_pkg::fix_t   ci_offset,
    output mandel_pkg::scale_t scaling,
    output mandel_pkg::csel_t  ctr_select,
    output mandel_pkg::ctr_t   max_ctr,
    output logic               frame_start
);
    import mandel_pkg::*;

    logic [2:0]          sen_sync;
    logic [2:0]          sclk_sync;
    logic [2:0]          sdata_sync;
    logic [CFG_BITS-1:0] cfg;
    logic                sclk_rise;
    logic                sen_fall;

    // Edge detect on the two oldest stages
    assign sclk_rise = !sclk_sync[2] && sclk_sync[1];
    assign sen_fall  = sen_sync[2] && !sen_sync[1];

    always_ff @(posedge clk or negedge combined_rst_n) begin
        if (!combined_rst_n) begin
            sen_sync    <= '0;
            sclk_sync   <= '0;
            sdata_sync  <= '0;
            frame_start <= 1'b0;
        end else begin
            sen_sync    <= {sen_sync[1:0], sen};
            sclk_sync   <= {sclk_sync[1:0], sclk};
            sdata_sync  <= {sdata_sync[1:0], sdata};
            frame_start <= sen_fall;    // One cycle pulse
        end
    end

    // First bit sent ends up at bit 0
    always_ff @(posedge clk) begin
        if (sen_sync[2] && sclk_rise) begin
            cfg <= {sdata_sync[2], cfg[CFG_BITS-1:1]};
        end
    end

    assign cr_offset  = cfg[CR_LSB +: BITWIDTH];
    assign ci_offset  = cfg[CI_LSB +: BITWIDTH];
    assign scaling    = cfg[SCALE_LSB +: 2];
    assign ctr_select = cfg[CSEL_LSB +: 2];
    assign max_ctr    = cfg[MAXCTR_LSB +: CTRWIDTH];

    // Synchronized enable still low when the start pulse goes out
    a_start_after_sen_low: assert property (
        @(posedge clk) disable iff (!combined_rst_n)
        frame_start |-> !sen_sync[1]
    ) else $error("frame_start while sen is still high");

endmodule

/* rtl/mandel_engine.sv */
// Mandelbrot iteration engine
// Runs z = z^2 + c in signed fixed point, one iteration per clock,
// and walks the pixel position in raster order

module mandel_engine #(
    parameter int BITWIDTH = mandel_pkg::BITWIDTH,
    parameter int CTRWIDTH = mandel_pkg::CTRWIDTH,
    parameter int IMG_W    = 8,
    parameter int IMG_H    = 6
) (
    input  logic                clk,
    input  logic                combined_rst_n,
    input  logic                run,
    input  logic                restart,
    input  mandel_pkg::fix_t    cr_offset,
    input  mandel_pkg::fix_t    ci_offset,
    input  mandel_pkg::scale_t  scaling,
    input  mandel_pkg::csel_t   ctr_select,
    input  mandel_pkg::ctr_t    max_ctr,
    output logic                running,
    output logic                done,
    output logic                last,
    output mandel_pkg::nibble_t pixel
);
    import mandel_pkg::*;

    localparam int FRAC = BITWIDTH - 3;
    localparam int PW   = 2 * BITWIDTH;     // Product width
    localparam int XW   = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int YW   = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    // 4.0 in the squared format
    localparam logic [PW:0] MAG_LIMIT = (PW + 1)'(4) << (2 * FRAC);

    eng_state_t                 state;
    logic [XW-1:0]              x;
    logic [YW-1:0]              y;
    logic [CTRWIDTH-1:0]        ctr;
    logic signed [BITWIDTH-1:0] zr;
    logic signed [BITWIDTH-1:0] zi;
    logic signed [BITWIDTH-1:0] x_step;
    logic signed [BITWIDTH-1:0] y_step;
    logic signed [BITWIDTH-1:0] c_r;
    logic signed [BITWIDTH-1:0] c_i;
    logic signed [PW-1:0]       zr_sq;
    logic signed [PW-1:0]       zi_sq;
    logic signed [PW-1:0]       zri;
    logic signed [PW-1:0]       zdiff;
    logic [PW:0]                mag;
    logic signed [BITWIDTH-1:0] zr_next;
    logic signed [BITWIDTH-1:0] zi_next;
    logic                       escape;
    logic                       at_end;
    logic [CTRWIDTH+3:0]        ctr_ext;

    // Point c for the current pixel
    assign x_step = BITWIDTH'(x) << scaling;
    assign y_step = BITWIDTH'(y) << scaling;
    assign c_r    = cr_offset + x_step;
    assign c_i    = ci_offset + y_step;

    assign zr_sq = zr * zr;
    assign zi_sq = zi * zi;
    assign zri   = zr * zi;
    assign zdiff = zr_sq - zi_sq;
    assign mag   = {1'b0, zr_sq} + {1'b0, zi_sq};    // Squares are never negative

    assign escape = (mag >= MAG_LIMIT) || (ctr == max_ctr);

    // Back to BITWIDTH, wrapping; 2*zr*zi folds into the shift
    assign zr_next = BITWIDTH'(zdiff >>> FRAC) + c_r;
    assign zi_next = BITWIDTH'(zri >>> (FRAC - 1)) + c_i;

    assign running = (state == eng_iter);
    assign at_end  = (x == XW'(IMG_W - 1)) && (y == YW'(IMG_H - 1));
    assign last    = done && at_end;

    // Bits above the counter read as zero
    assign ctr_ext = {4'b0000, ctr};
    assign pixel   = nibble_t'(ctr_ext >> ctr_select);

    always_ff @(posedge clk or negedge combined_rst_n) begin
        if (!combined_rst_n) begin
            state <= eng_idle;
            ctr   <= '0;
            done  <= 1'b0;
            x     <= '0;
            y     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                eng_idle: begin
                    if (run) begin
                        ctr   <= '0;
                        state <= eng_iter;
                    end
                end
                eng_iter: begin
                    if (escape) begin
                        done  <= 1'b1;      // Count stays as the result
                        state <= eng_idle;
                    end else begin
                        ctr <= ctr + 1'b1;
                    end
                end
                default: state <= eng_idle;
            endcase

            // Raster walk
            if (restart) begin
                x <= '0;
                y <= '0;
            end else if (done) begin
                if (x == XW'(IMG_W - 1)) begin
                    x <= '0;
                    y <= at_end ? '0 : y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run && state == eng_idle) begin
            zr <= '0;
            zi <= '0;
        end else if (running && !escape) begin
            zr <= zr_next;
            zi <= zi_next;
        end
    end

    a_ctr_bound: assert property (
        @(posedge clk) disable iff (!combined_rst_n)
        running |-> ctr <= max_ctr
    ) else $error("iteration count beyond max_ctr");

    // Sequencer must wait for the pixel to finish
    a_no_run_busy: assert property (
        @(posedge clk) disable iff (!combined_rst_n)
        run |-> !running
    ) else $error("run while engine is busy");

endmodule

/* rtl/render_sequencer.sv */
// Render sequencer
// Starts the frame, launches one pixel at a time and holds off
// while the output buffer has no room

module render_sequencer (
    input  logic clk,
    input  logic combined_rst_n,
    input  logic frame_start,
    input  logic space,
    input  logic done,
    input  logic last,
    output logic run,
    output logic restart
);
    import mandel_pkg::*;

    seq_state_t state;

    // Pulses come straight from the state so run follows frame_start by one cycle
    assign restart = (state == launch);
    assign run     = (state == launch) || (state == wait_space && space);

    always_ff @(posedge clk or negedge combined_rst_n) begin
        if (!combined_rst_n) begin
            state <= idle;
        end else begin
            case (state)
                // Wait for the serial port to close
                idle: begin
                    if (frame_start) begin
                        state <= launch;
                    end
                end

                // Clear the position and kick the first pixel
                launch: begin
                    state <= compute;
                end

                // Next pixel once the buffer can take it
                wait_space: begin
                    if (space) begin
                        state <= compute;
                    end
                end

                compute: begin
                    if (done) begin
                        if (last) begin
                            state <= idle;  // Frame complete
                        end else begin
                            state <= wait_space;
                        end
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* rtl/pixel_out.sv */
// Pixel output buffer
// One entry holding the last finished pixel, valid/ready towards
// the consumer, and a flag once the final pixel has been taken

module pixel_out (
    input  logic                clk,
    input  logic                combined_rst_n,
    input  logic                done,
    input  logic                last,
    input  mandel_pkg::nibble_t pixel,
    input  logic                pixel_ready,
    input  logic                frame_start,
    output mandel_pkg::nibble_t pixel_data,
    output logic                pixel_valid,
    output logic                space,
    output logic                frame_done
);
    import mandel_pkg::*;

    logic    full;
    logic    last_q;
    nibble_t data_q;
    logic    accept;

    assign accept      = full && pixel_ready;
    assign space       = !full || pixel_ready;     // Empty or draining now
    assign pixel_valid = full;
    assign pixel_data  = data_q;

    always_ff @(posedge clk or negedge combined_rst_n) begin
        if (!combined_rst_n) begin
            full       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            if (done) begin
                full <= 1'b1;
            end else if (accept) begin
                full <= 1'b0;
            end

            if (frame_start) begin
                frame_done <= 1'b0;
            end else if (accept && last_q) begin
                frame_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            data_q <= pixel;
            last_q <= last;     // Tag travels with the pixel
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!combined_rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_data)
    ) else $error("pixel_data changed under back-pressure");

endmodule

/* rtl/tiny_mandel_top.sv */
// Mandelbrot renderer top level
// Reset combiner, serial config port, sequencer, iteration engine
// and the output buffer

module tiny_mandel_top #(
    parameter int BITWIDTH = mandel_pkg::BITWIDTH,
    parameter int CTRWIDTH = mandel_pkg::CTRWIDTH,
    parameter int IMG_W    = 8,
    parameter int IMG_H    = 6
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sen,
    input  logic                sclk,
    input  logic                sdata,
    output mandel_pkg::nibble_t pixel_data,
    output logic                pixel_valid,
    input  logic                pixel_ready,
    output logic                frame_done
);
    import mandel_pkg::*;

    logic    latched_rst_n;
    logic    combined_rst_n;
    fix_t    cr_offset;
    fix_t    ci_offset;
    scale_t  scaling;
    csel_t   ctr_select;
    ctr_t    max_ctr;
    logic    frame_start;
    logic    run;
    logic    restart;
    logic    running;
    logic    done;
    logic    last;
    nibble_t pixel;
    logic    space;

    // Reset sampled on the falling edge, released only when both agree
    always_ff @(negedge clk) begin
        latched_rst_n <= rst_n;
    end
    assign combined_rst_n = latched_rst_n && rst_n;

    config_shift_in #(
        .BITWIDTH(BITWIDTH),
        .CTRWIDTH(CTRWIDTH)
    ) u_cfg (
        .clk           (clk),
        .combined_rst_n(combined_rst_n),
        .sen           (sen),
        .sclk          (sclk),
        .sdata         (sdata),
        .cr_offset     (cr_offset),
        .ci_offset     (ci_offset),
        .scaling       (scaling),
        .ctr_select    (ctr_select),
        .max_ctr       (max_ctr),
        .frame_start   (frame_start)
    );

    render_sequencer u_seq (
        .clk           (clk),
        .combined_rst_n(combined_rst_n),
        .frame_start   (frame_start),
        .space         (space),
        .done          (done),
        .last          (last),
        .run           (run),
        .restart       (restart)
    );

    mandel_engine #(
        .BITWIDTH(BITWIDTH),
        .CTRWIDTH(CTRWIDTH),
        .IMG_W   (IMG_W),
        .IMG_H   (IMG_H)
    ) u_engine (
        .clk           (clk),
        .combined_rst_n(combined_rst_n),
        .run           (run),
        .restart       (restart),
        .cr_offset     (cr_offset),
        .ci_offset     (ci_offset),
        .scaling       (scaling),
        .ctr_select    (ctr_select),
        .max_ctr       (max_ctr),
        .running       (running),
        .done          (done),
        .last          (last),
        .pixel         (pixel)
    );

    pixel_out u_out (
        .clk           (clk),
        .combined_rst_n(combined_rst_n),
        .done          (done),
        .last          (last),
        .pixel         (pixel),
        .pixel_ready   (pixel_ready),
        .frame_start   (frame_start),
        .pixel_data    (pixel_data),
        .pixel_valid   (pixel_valid),
        .space         (space),
        .frame_done    (frame_done)
    );

    // A finished pixel must find the buffer empty or draining
    a_done_has_space: assert property (
        @(posedge clk) disable iff (!combined_rst_n)
        $fell(running) |-> space
    ) else $error("pixel finished while the output buffer was still full");

endmodule

/* dv/tb_tiny_mandel.sv */
// Testbench for the Mandelbrot renderer
// Sends serial configuration words, predicts every pixel from the
// iteration rule and checks the output stream with assertions

module tb_tiny_mandel;
    import mandel_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int IMG_W         = 4;
    localparam int IMG_H         = 3;
    localparam int NPIX          = IMG_W * IMG_H;
    localparam int FIX_W         = mandel_pkg::BITWIDTH;
    localparam int FRAC          = FIX_W - 3;
    localparam int HALF          = 4;       // Clocks per serial clock phase
    localparam int FRAMES        = 8;
    localparam int ITER_BOUND    = 127;     // Largest max_ctr used
    localparam int SERIAL_CYCLES = 300;
    localparam int HOLD_CYCLES   = 150;
    localparam int WATCHDOG_CYCLES =
        (FRAMES * NPIX * (ITER_BOUND + 2) + FRAMES * SERIAL_CYCLES + HOLD_CYCLES) * 2;

    logic       clk;
    logic       rst_n;
    logic       sen;
    logic       sclk;
    logic       sdata;
    logic [3:0] pixel_data;
    logic       pixel_valid;
    logic       pixel_ready;
    logic       frame_done;

    logic [3:0] exp_q[$];       // Expected pixels, raster order
    logic [3:0] exp_head;
    int         exp_left;
    logic       hold_low;       // Forces back-pressure
    logic       armed;          // Low from a reset until a frame is configured

    tiny_mandel_top #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sen        (sen),
        .sclk       (sclk),
        .sdata      (sdata),
        .pixel_data (pixel_data),
        .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    // Sign-extend the low FIX_W bits, as the datapath wraps
    function automatic int wrap_fix(input int v);
        int t;
        t = v & ((1 << FIX_W) - 1);
        if (t >= (1 << (FIX_W - 1))) begin
            t = t - (1 << FIX_W);
        end
        return t;
    endfunction

    function automatic logic [3:0] model_pixel(input int cr, input int ci, input int sc,
                                               input int csel, input int mx,
                                               input int x, input int y);
        int c_r, c_i, zr, zi, zr_new, rr, ii, ri, n;
        bit stop;
        c_r  = wrap_fix(cr + (x << sc));
        c_i  = wrap_fix(ci + (y << sc));
        zr   = 0;
        zi   = 0;
        n    = 0;
        stop = 1'b0;
        while (!stop) begin
            rr = zr * zr;
            ii = zi * zi;
            ri = zr * zi;
            if (rr + ii >= (4 << (2 * FRAC)) || n == mx) begin
                stop = 1'b1;
            end else begin
                zr_new = wrap_fix(((rr - ii) >>> FRAC) + c_r);
                zi     = wrap_fix(((2 * ri) >>> FRAC) + c_i);
                zr     = zr_new;
                n++;
            end
        end
        return 4'((n >> csel) & 15);
    endfunction

    task automatic send_config(input logic [CFG_BITS-1:0] word);
        int i;
        sen = 1'b1;
        repeat (HALF) @(negedge clk);
        for (i = 0; i < CFG_BITS; i++) begin
            sdata = word[i];    // LSB first, changes while sclk is low
            sclk  = 1'b0;
            repeat (HALF) @(negedge clk);
            sclk = 1'b1;
            repeat (HALF) @(negedge clk);
        end
        sclk = 1'b0;
        repeat (HALF) @(negedge clk);
        sen   = 1'b0;           // Falling enable starts the frame
        armed = 1'b1;
    endtask

    task automatic start_frame(input int cr, input int ci, input int sc,
                               input int csel, input int mx);
        int x, y;
        for (y = 0; y < IMG_H; y++) begin
            for (x = 0; x < IMG_W; x++) begin
                exp_q.push_back(model_pixel(cr, ci, sc, csel, mx, x, y));
            end
        end
        send_config({7'(mx), 2'(csel), 2'(sc), 11'(ci), 11'(cr)});
    endtask

    task automatic finish_frame();
        while (frame_done) @(negedge clk);     // Old flag clears on frame start
        while (!frame_done) @(negedge clk);
    endtask

    task automatic run_frame(input int cr, input int ci, input int sc,
                             input int csel, input int mx);
        start_frame(cr, ci, sc, csel, mx);
        finish_frame();
    endtask

    // Scoreboard head, advanced on every accepted pixel
    always @(posedge clk) begin
        if (rst_n && pixel_valid && pixel_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_left <= exp_q.size();
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : 4'h0;
    end

    initial begin
        void'($urandom(32'hcc5f));
        pixel_ready = 1'b0;
        forever begin
            @(negedge clk);
            pixel_ready = hold_low ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    a_pixel_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid && pixel_ready |-> pixel_data == exp_head
    ) else fail_run($sformatf("ERR pixel_data got %h expected %h",
                              $sampled(pixel_data), $sampled(exp_head)));

    a_no_extra: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid && pixel_ready |-> exp_left > 0
    ) else fail_run("A pixel was accepted beyond the end of the frame");

    a_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_data)
    ) else fail_run($sformatf("ERR pixel_data %h pixel_valid %h after a stalled cycle",
                              $sampled(pixel_data), $sampled(pixel_valid)));

    a_done_after_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(frame_done) |-> $past(pixel_valid && pixel_ready) && exp_left == 0
    ) else fail_run("frame_done rose before the last pixel was accepted");

    a_done_cleared: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid |-> !frame_done
    ) else fail_run("frame_done still high while a new pixel is offered");

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        !armed |-> !pixel_valid && !frame_done
    ) else fail_run("Output active after reset before a frame was configured");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog timeout, frames did not complete in time");
    end

    initial begin
        rst_n    = 1'b0;
        sen      = 1'b0;
        sclk     = 1'b0;
        sdata    = 1'b0;
        hold_low = 1'b0;
        armed    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        run_frame(-192, 8, 3, 0, 40);          // Near the neck at -0.75
        start_frame(60, -8, 2, 1, 60);          // Long stall inside this one
        while (!pixel_valid) @(negedge clk);
        hold_low = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        hold_low = 1'b0;
        finish_frame();
        run_frame(-400, 100, 1, 2, 90);
        run_frame(-64, 0, 0, 3, 127);           // Inside the set, count saturates
        run_frame(-300, 50, 2, 0, 0);           // max_ctr 0 gives all zeros
        run_frame(-128, 0, 0, 2, 100);          // Slice of max_ctr

        // Reset in the middle of a frame
        start_frame(-192, 16, 3, 1, 50);
        while (exp_left > NPIX - 3) @(negedge clk);
        armed = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        exp_q.delete();
        rst_n = 1'b1;
        repeat (50) @(negedge clk);
        run_frame(-200, -20, 2, 0, 70);

        repeat (4) @(negedge clk);
        if (exp_left != 0) begin
            fail_run("Expected pixels left over at the end of the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* flist.f */
rtl/mandel_pkg.sv
rtl/config_shift_in.sv
rtl/mandel_engine.sv
rtl/render_sequencer.sv
rtl/pixel_out.sv
rtl/tiny_mandel_top.sv
dv/tb_tiny_mandel.sv

/* Bender.yml */
package:
  name: tiny_mandel

sources:
  - rtl/mandel_pkg.sv
  - rtl/config_shift_in.sv
  - rtl/mandel_engine.sv
  - rtl/render_sequencer.sv
  - rtl/pixel_out.sv
  - rtl/tiny_mandel_top.sv
  - target: test
    files:
      - dv/tb_tiny_mandel.sv
